//--- verilog.f
+incdir+include
source/mem_pkg.sv
source/store_align.sv
source/load_extend.sv
source/data_ram.sv
source/uart_tx_port.sv
source/lsu_ctl.sv
source/lsu_top.sv
tests/tb_lsu.sv

//--- run.sh
#!/bin/sh
# build the lsu testbench with verilator, run it and scan the log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_lsu -f verilog.f -o tb_lsu_sim &&
  ./obj_dir/tb_lsu_sim | tee sim.log &&
  test -s sim.log &&
  ! grep -q "FAIL: see errors above" sim.log ||
  { echo "simulation failed"; exit 1; }
echo "simulation passed"

//--- tests/tb_lsu.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_map.svh"

module tb_lsu import mem_pkg::*; ();

  localparam int RAM_WORDS = 256;
  localparam int RAM_BYTES = RAM_WORDS * 4;
  localparam int N_WORD    = 40;
  localparam int N_SUB     = 60;
  localparam int N_ERR     = 30;
  localparam int N_UART    = 30;
  localparam int N_MIX     = 80;
  localparam int N_REQ     = RAM_WORDS + N_WORD + N_SUB + 2 * N_ERR + N_UART + 2 * N_MIX;
  localparam int MAX_CYC   = N_REQ * 12;   // worst-case stall per request

  logic       clk;
  logic       rst_n;
  mem_req_t   req;
  logic       req_valid;
  logic       req_ready;
  mem_rsp_t   rsp;
  logic       rsp_valid;
  logic       rsp_ready;
  logic [7:0] uart_data;
  logic       uart_valid;
  logic       uart_ready;

  lsu_top #(.RAM_WORDS(RAM_WORDS)) uut (.*);

  logic [31:0] seed = 32'h2145;
  logic [7:0]  ram_model [RAM_BYTES];
  mem_rsp_t    exp_rsp [$];
  logic [7:0]  exp_uart [$];
  mem_rsp_t    last_rsp;
  logic        held;        // response seen stalled last cycle
  logic        rsp_rand;
  logic        uart_rand;
  int          cyc;
  int          due_cyc;
  int          errors;
  int          n_ld;
  int          n_rsp;
  int          n_uart;
  int          tests_run;
  int          tests_failed;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYC) begin
      $display("timeout: no end of test after %0d cycles", MAX_CYC);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus helpers and reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] rnd();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed ^ (seed >> 15);   // fold high bits into the low ones
  endfunction

  function automatic mem_req_t make_req(logic st, logic uns, mem_width_e w,
                                        logic [31:0] a, logic [31:0] d);
    return '{is_store: st, is_unsigned: uns, width: w, addr: a, wdata: d};
  endfunction

  function automatic logic [1:0] lane_offset(mem_width_e w);
    logic [31:0] r;
    r = rnd();
    return (w == MEM_BYTE) ? r[1:0] : {r[0], 1'b0};
  endfunction

  function automatic mem_req_t bad_load(logic [31:0] a);
    logic [31:0] r;
    logic [31:0] s;
    r = rnd();
    s = rnd();
    case (r[1:0])
      2'd0:    return make_req(1'b0, r[2], MEM_HALF, a + {s[1], 1'b1}, 32'd0);
      2'd1:    return make_req(1'b0, r[2], MEM_WORD, a + 32'd1 + (s % 3), 32'd0);
      2'd2:    return make_req(1'b0, r[2], MEM_RSVD, a, 32'd0);
      default: return make_req(1'b0, r[2], MEM_WORD, RAM_BYTES + {s[23:0], 2'b00}, 32'd0);
    endcase
  endfunction

  // the address must be a multiple of the access size
  function automatic logic legal_req(mem_req_t r);
    logic [31:0] size;
    size = 32'd1 << r.width;
    if (r.width == MEM_RSVD || (r.addr & (size - 32'd1)) != 32'd0) return 1'b0;
    return ((r.addr - `RAM_BASE) < 32'(RAM_BYTES)) || (r.addr == `UART_TX_ADDR);
  endfunction

  task automatic flag_error(string msg);
    errors++;
    $display("ERROR %0t ns: %s", $time, msg);
  endtask

  task automatic drive_ready();
    rsp_ready  = rsp_rand ? ((rnd() % 3) == 0) : 1'b1;
    uart_ready = uart_rand ? ((rnd() % 4) == 0) : 1'b1;
  endtask

  // pend is the buffer state seen before this edge
  task automatic accept_model(mem_req_t r, logic pend);
    int          nb;
    logic [31:0] v;
    mem_rsp_t    e;
    nb = 1 << r.width;
    if (r.is_store) begin
      if (legal_req(r) && r.addr == `UART_TX_ADDR) exp_uart.push_back(r.wdata[7:0]);
      else if (legal_req(r)) begin
        for (int i = 0; i < nb; i++) ram_model[r.addr + i] = r.wdata[8*i +: 8];
      end
    end else begin
      n_ld++;
      v = 32'd0;
      if (!legal_req(r)) e = '{rdata: 32'd0, err: 1'b1};
      else if (r.addr == `UART_TX_ADDR) e = '{rdata: {31'd0, pend}, err: 1'b0};
      else begin
        for (int i = 0; i < nb; i++) v[8*i +: 8] = ram_model[r.addr + i];
        if (!r.is_unsigned && nb < 4 && v[8*nb-1]) v = v | ~((32'd1 << (8 * nb)) - 1);
        e = '{rdata: v, err: 1'b0};
      end
      exp_rsp.push_back(e);
      due_cyc = cyc + 2;
    end
  endtask

  task automatic watch_outputs();
    logic rsp_xfer;
    rsp_xfer = rsp_valid & rsp_ready;
    if (held && (!rsp_valid || rsp !== last_rsp)) flag_error("response changed before transfer");
    held     = rsp_valid & ~rsp_ready;
    last_rsp = rsp;
    if (req_ready && exp_rsp.size() != 0 && !rsp_xfer) flag_error("request taken during a load");
    if (req_ready && req_valid && req.is_store && req.addr == `UART_TX_ADDR &&
        exp_uart.size() != 0) flag_error("uart store taken while the buffer is full");
    if (rsp_valid && exp_rsp.size() == 0) flag_error("response without an open load");
    if (exp_rsp.size() != 0 && (rsp_valid ? cyc < due_cyc : cyc >= due_cyc)) begin
      flag_error("load response not one cycle after acceptance");
    end
    if (rsp_xfer) n_rsp++;
    if (rsp_xfer && exp_rsp.size() != 0) begin
      if (rsp !== exp_rsp[0]) begin
        flag_error($sformatf("load data %h err %b, expected %h err %b",
                             rsp.rdata, rsp.err, exp_rsp[0].rdata, exp_rsp[0].err));
      end
      void'(exp_rsp.pop_front());
    end
    if (uart_valid != (exp_uart.size() != 0)) flag_error("uart_valid differs from buffer state");
    if (uart_valid && uart_ready && exp_uart.size() != 0) begin
      if (uart_data !== exp_uart[0]) begin
        flag_error($sformatf("uart byte %h, expected %h", uart_data, exp_uart[0]));
      end
      void'(exp_uart.pop_front());
      n_uart++;
    end
  endtask

  task automatic send(mem_req_t r);
    logic pend;
    logic done;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      req       = r;
      req_valid = 1'b1;
      drive_ready();
      #1;
      pend = (exp_uart.size() != 0);
      watch_outputs();
      if (req_ready) begin
        accept_model(r, pend);
        done = 1'b1;
      end
    end
  endtask

  task automatic idle();
    @(negedge clk);
    req_valid = 1'b0;
    drive_ready();
    #1;
    watch_outputs();
  endtask

  task automatic drain();
    int n;
    rsp_rand  = 1'b0;
    uart_rand = 1'b0;
    n = 0;
    idle();
    while ((exp_rsp.size() != 0 || exp_uart.size() != 0) && n < 20) begin
      idle();
      n++;
    end
    if (exp_rsp.size() != 0) flag_error("load response never arrived");
    if (exp_uart.size() != 0) flag_error("uart byte never left the buffer");
  endtask

  task automatic do_op(int kind);
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] r;
    mem_width_e  w;
    a = (rnd() % RAM_WORDS) * 4;
    d = rnd();
    r = rnd();
    w = r[3] ? MEM_HALF : MEM_BYTE;
    case (kind)
      0: send(make_req(1'b1, 1'b0, MEM_WORD, a, d));
      1: send(make_req(1'b1, 1'b0, w, a + lane_offset(w), d));
      2: send(make_req(1'b0, r[4], MEM_WORD, a, 32'd0));
      3: send(make_req(1'b0, r[4], w, a + lane_offset(w), 32'd0));
      4: send(bad_load(a));
      5: begin
        // odd offset is illegal for half, word and the reserved code
        send(make_req(1'b1, 1'b0, mem_width_e'(1 + (r % 3)), a + {r[5], 1'b1}, d));
        send(make_req(1'b0, 1'b0, MEM_WORD, a, 32'd0));
      end
      6: send(make_req(1'b1, 1'b0, MEM_BYTE, `UART_TX_ADDR, d));
      default: send(make_req(1'b0, 1'b0, MEM_WORD, `UART_TX_ADDR, 32'd0));
    endcase
  endtask

  task automatic finish_test(string name, int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    int e0;
    rst_n      = 1'b0;
    req        = '0;
    req_valid  = 1'b0;
    rsp_ready  = 1'b1;
    uart_ready = 1'b1;
    rsp_rand   = 1'b0;
    uart_rand  = 1'b0;
    held       = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    e0 = errors;
    idle();
    if (!req_ready || rsp_valid || uart_valid) flag_error("outputs not idle after reset");
    finish_test("reset", e0);

    e0 = errors;
    for (int i = 0; i < RAM_WORDS; i++) begin
      send(make_req(1'b1, 1'b0, MEM_WORD, i * 4, (i + 1) * 32'h9e37_79b9));   // known contents
    end
    for (int i = 0; i < N_WORD; i++) do_op((rnd() % 2) * 2);
    drain();
    finish_test("word round trip", e0);

    e0 = errors;
    for (int i = 0; i < N_SUB; i++) do_op(1 + (rnd() % 3));
    drain();
    finish_test("sub-word lanes", e0);

    e0 = errors;
    for (int i = 0; i < N_ERR; i++) do_op(4 + (rnd() % 2));
    drain();
    finish_test("errors", e0);

    e0 = errors;
    uart_rand = 1'b1;
    for (int i = 0; i < N_UART; i++) do_op(((rnd() % 4) == 0) ? 7 : 6);
    drain();
    finish_test("uart path", e0);

    e0 = errors;
    rsp_rand  = 1'b1;
    uart_rand = 1'b1;
    for (int i = 0; i < N_MIX; i++) do_op(rnd() % 8);
    drain();
    if (n_rsp != n_ld) flag_error($sformatf("%0d responses for %0d loads", n_rsp, n_ld));
    finish_test("back-pressure", e0);

    $display("%0d tests, %0d failed, %0d errors, %0d loads, %0d responses, %0d uart bytes",
             tests_run, tests_failed, errors, n_ld, n_rsp, n_uart);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top import mem_pkg::*; #(
  parameter int RAM_WORDS = 1024
) (
  input  var logic     clk,
  input  var logic     rst_n,
  input  var mem_req_t req,
  input  var logic     req_valid,
  output logic         req_ready,
  output mem_rsp_t     rsp,
  output logic         rsp_valid,
  input  var logic     rsp_ready,
  output logic [7:0]   uart_data,
  output logic         uart_valid,
  input  var logic     uart_ready
);

  localparam int AW = $clog2(RAM_WORDS);

  logic [1:0]    offset;
  logic [3:0]    be;
  logic [31:0]   wdata_shifted;
  ram_wr_t       ram_wr;
  logic [AW-1:0] rd_index;
  logic [31:0]   rd_word;
  logic [31:0]   load_data;
  mem_width_e    ld_width;
  logic          ld_unsigned;
  logic          tx_push;
  logic [7:0]    tx_byte;
  logic          tx_full;

  lsu_ctl #(.RAM_WORDS(RAM_WORDS)) u_ctl (
    .clk, .rst_n, .req, .req_valid, .req_ready, .rsp, .rsp_valid, .rsp_ready,
    .offset, .be, .wdata_shifted, .ram_wr, .rd_index, .load_data,
    .ld_width, .ld_unsigned, .tx_push, .tx_byte, .tx_full
  );

  store_align u_store (
    .width(req.width), .offset, .wdata(req.wdata), .be, .wdata_shifted
  );

  data_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
    .clk, .wr(ram_wr), .rd_index, .rd_word
  );

  load_extend u_load (
    .word(rd_word), .width(ld_width), .offset, .is_unsigned(ld_unsigned),
    .data(load_data)
  );

  uart_tx_port u_uart (
    .clk, .rst_n, .push(tx_push), .byte_in(tx_byte), .uart_ready,
    .uart_data, .uart_valid, .full(tx_full)
  );

endmodule

`default_nettype wire

//--- source/lsu_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_ctl import mem_pkg::*; #(
  parameter int RAM_WORDS = 1024,
  localparam int AW = $clog2(RAM_WORDS)
) (
  input  var logic        clk,
  input  var logic        rst_n,
  input  var mem_req_t    req,
  input  var logic        req_valid,
  output logic            req_ready,
  output mem_rsp_t        rsp,
  output logic            rsp_valid,
  input  var logic        rsp_ready,
  output logic [1:0]      offset,
  input  var logic [3:0]  be,
  input  var logic [31:0] wdata_shifted,
  output ram_wr_t         ram_wr,
  output logic [AW-1:0]   rd_index,
  input  var logic [31:0] load_data,
  output mem_width_e      ld_width,
  output logic            ld_unsigned,
  output logic            tx_push,
  output logic [7:0]      tx_byte,
  input  var logic        tx_full
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address classification
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [31:0] ram_off;
  logic        in_ram;
  logic        is_uart;
  logic        aligned;
  logic        legal;

  assign ram_off = req.addr - RAM_BASE_ADDR;
  assign in_ram  = (ram_off[31:AW+2] == '0);
  assign is_uart = (req.addr == UART_ADDR);

  always_comb begin
    case (req.width)
      MEM_BYTE: aligned = 1'b1;
      MEM_HALF: aligned = ~req.addr[0];
      MEM_WORD: aligned = (req.addr[1:0] == 2'b00);
      default:  aligned = 1'b0;          // reserved code
    endcase
  end

  assign legal = aligned & (in_ram | is_uart);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // handshake
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic ld_pend;    // load accepted, ram word arrives this cycle
  logic accept;
  logic ld_accept;
  logic tx_block;

  assign tx_block  = is_uart & req.is_store & tx_full;
  assign req_ready = ~ld_pend & (~rsp_valid | rsp_ready) & ~tx_block;
  assign accept    = req_valid & req_ready;
  assign ld_accept = accept & ~req.is_store;

  // load context captured at acceptance
  logic [1:0] ld_off_q;
  logic       ld_err_q;
  logic       ld_uart_q;
  logic       ld_stat_q;

  always_ff @(posedge clk) begin
    if (ld_accept) begin
      ld_width    <= req.width;
      ld_unsigned <= req.is_unsigned;
      ld_off_q    <= req.addr[1:0];
      ld_err_q    <= ~legal;
      ld_uart_q   <= is_uart;
      ld_stat_q   <= tx_full;          // buffer state seen by this load
    end
  end

  // offset follows the live request except while a load is waiting on ram
  assign offset = ld_pend ? ld_off_q : req.addr[1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ld_pend   <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      ld_pend <= ld_accept;
      if (ld_pend) begin
        rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
        rsp_valid <= 1'b0;
      end
    end
  end

  mem_rsp_t rsp_next;

  always_comb begin
    if (ld_err_q) begin
      rsp_next = '{rdata: 32'd0, err: 1'b1};
    end else if (ld_uart_q) begin
      rsp_next = '{rdata: {31'd0, ld_stat_q}, err: 1'b0};
    end else begin
      rsp_next = '{rdata: load_data, err: 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (ld_pend) rsp <= rsp_next;      // held until the next load completes
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ram and uart side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    ram_wr.index = ram_off[31:2];
    ram_wr.be    = (accept & req.is_store & legal & in_ram) ? be : 4'b0000;
    ram_wr.data  = wdata_shifted;
  end

  assign rd_index = ram_off[AW+1:2];

  assign tx_push = accept & req.is_store & is_uart & legal;
  assign tx_byte = req.wdata[7:0];

endmodule

`default_nettype wire

//--- source/uart_tx_port.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_port (
  input  var logic       clk,
  input  var logic       rst_n,
  input  var logic       push,
  input  var logic [7:0] byte_in,
  input  var logic       uart_ready,
  output logic [7:0]     uart_data,
  output logic           uart_valid,
  output logic           full
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      uart_valid <= 1'b0;
    end else if (push) begin
      uart_valid <= 1'b1;
    end else if (uart_ready) begin
      uart_valid <= 1'b0;              // byte taken by the serializer
    end
  end

  always_ff @(posedge clk) begin
    if (push) uart_data <= byte_in;
  end

  assign full = uart_valid;   // single entry

endmodule

`default_nettype wire

//--- source/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram import mem_pkg::*; #(
  parameter int RAM_WORDS = 1024,
  localparam int AW = $clog2(RAM_WORDS)
) (
  input  var logic          clk,
  input  var ram_wr_t       wr,
  input  var logic [AW-1:0] rd_index,
  output logic [31:0]       rd_word
);

  logic [3:0][7:0] mem [RAM_WORDS];
  logic [AW-1:0]   wr_index;

  assign wr_index = wr.index[AW-1:0];

  // byte lanes are written one by one
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (wr.be[i]) begin
        mem[wr_index][i] <= wr.data[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_word <= mem[rd_index];    // old data on a same-edge write
  end

endmodule

`default_nettype wire

//--- source/load_extend.sv
`timescale 1ns/1ps
`default_nettype none

module load_extend import mem_pkg::*; (
  input  var logic [31:0] word,
  input  var mem_width_e  width,
  input  var logic [1:0]  offset,
  input  var logic        is_unsigned,
  output logic [31:0]     data
);

  lane_word_u lw;
  logic [7:0]  b_sel;
  logic [15:0] h_sel;
  logic        b_sign;
  logic        h_sign;

  assign lw     = word;
  assign b_sel  = lw.b[offset];
  assign h_sel  = lw.h[offset[1]];
  assign b_sign = ~is_unsigned & b_sel[7];     // zero when unsigned
  assign h_sign = ~is_unsigned & h_sel[15];

  always_comb begin
    case (width)
      MEM_BYTE: data = {{24{b_sign}}, b_sel};
      MEM_HALF: data = {{16{h_sign}}, h_sel};
      default:  data = word;                   // word passes through
    endcase
  end

endmodule

`default_nettype wire

//--- source/store_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_align import mem_pkg::*; (
  input  var mem_width_e  width,
  input  var logic [1:0]  offset,
  input  var logic [31:0] wdata,
  output logic [3:0]      be,
  output logic [31:0]     wdata_shifted
);

  lane_word_u lw;

  // data is copied into every lane, the enables pick the ones written
  always_comb begin
    lw = '0;
    be = 4'b0000;
    case (width)
      MEM_BYTE: begin
        lw.b = {4{wdata[7:0]}};
        be   = 4'b0001 << offset;
      end
      MEM_HALF: begin
        lw.h = {2{wdata[15:0]}};
        be   = 4'b0011 << {offset[1], 1'b0};   // lower or upper half
      end
      MEM_WORD: begin
        lw = wdata;
        be = 4'b1111;
      end
      default: begin
        lw = '0;
        be = 4'b0000;
      end
    endcase
  end

  assign wdata_shifted = lw;

endmodule

`default_nettype wire

//--- source/mem_pkg.sv
`default_nettype none

package mem_pkg;

`include "mem_map.svh"

  localparam logic [31:0] UART_ADDR     = `UART_TX_ADDR;
  localparam logic [31:0] RAM_BASE_ADDR = `RAM_BASE;

  typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10,
    MEM_RSVD = 2'b11   // never legal
  } mem_width_e;

  typedef struct packed {
    logic        is_store;
    logic        is_unsigned;
    mem_width_e  width;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } mem_rsp_t;

  // one word seen as byte lanes or half lanes
  typedef union packed {
    logic [3:0][7:0]  b;
    logic [1:0][15:0] h;
  } lane_word_u;

  typedef struct packed {
    logic [29:0] index;   // word index, ram keeps the low bits
    logic [3:0]  be;
    logic [31:0] data;
  } ram_wr_t;

endpackage

`default_nettype wire

//--- include/mem_map.svh
`ifndef MEM_MAP_SVH
`define MEM_MAP_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data-side address map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define UART_TX_ADDR 32'h1000_0000
`define RAM_BASE     32'h0000_0000

`endif
